// File: compile.f
+incdir+hdl
hdl/id_pkg.sv
hdl/id_pipe_reg.sv
hdl/id_decoder.sv
hdl/id_imm_gen.sv
hdl/id_operand_sel.sv
hdl/id_stage_top.sv
dv/id_stage_properties.sv
dv/id_stage_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the decode stage testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/100ps \
    -f compile.f --top-module id_stage_tb -o id_stage_sim
out=$(./obj_dir/id_stage_sim +verilator+error+limit+100)
echo "$out"
grep -qF '*** PASSED ***' <<< "$out"

// File: dv/id_stage_tb.sv
// random decode stage testbench; gpr and csr values change only between tests, x0 not special
`timescale 1ns/100ps
`include "id_params.svh"

module id_stage_tb;

    logic                 clk;
    logic                 rst;
    logic                 valid_id;
    id_pkg::xword_t       pc_id;
    logic [`ID_ILEN-1:0]  inst_id;
    logic                 ready_ex;
    id_pkg::xword_t       gpr [`ID_NREG];
    logic [`ID_NREG-1:0]  gpr_busy;
    id_pkg::xword_t       mstatus;
    id_pkg::xword_t       mtvec;
    id_pkg::xword_t       mepc;
    id_pkg::xword_t       mcause;
    logic                 ready_id;
    logic                 valid_ex;
    id_pkg::xword_t       pc_ex;
    logic [`ID_ILEN-1:0]  inst_ex;
    id_pkg::op_e          op;
    logic [`ID_REG_W-1:0] rd;
    logic                 wen;
    id_pkg::xword_t       src_a;
    id_pkg::xword_t       src_b;
    id_pkg::xword_t       imm;

    logic [31:0]          rng_state = 32'h7177_9972;
    logic [31:0]          q_inst [$];           // accepted, not yet consumed
    id_pkg::xword_t       q_pc [$];
    string                cur_test;
    int                   n_checks = 0;
    int                   n_errors = 0;
    int                   test_errors = 0;
    bit                   timed_out = 1'b0;     // later tests are skipped once set

    // funct3-indexed op tables of the reference model
    id_pkg::op_e reg_ops [8] = '{id_pkg::OP_ADD, id_pkg::OP_SLL, id_pkg::OP_SLT,
                                 id_pkg::OP_SLTU, id_pkg::OP_XOR, id_pkg::OP_SRL,
                                 id_pkg::OP_OR, id_pkg::OP_AND};
    id_pkg::op_e imm_ops [8] = '{id_pkg::OP_ADDI, id_pkg::OP_NONE, id_pkg::OP_SLTI,
                                 id_pkg::OP_SLTIU, id_pkg::OP_XORI, id_pkg::OP_NONE,
                                 id_pkg::OP_ORI, id_pkg::OP_ANDI};    // shifts by funct6
    id_pkg::op_e load_ops [8] = '{id_pkg::OP_LB, id_pkg::OP_LH, id_pkg::OP_LW,
                                  id_pkg::OP_LD, id_pkg::OP_LBU, id_pkg::OP_LHU,
                                  id_pkg::OP_LWU, id_pkg::OP_NONE};
    id_pkg::op_e store_ops [8] = '{id_pkg::OP_SB, id_pkg::OP_SH, id_pkg::OP_SW,
                                   id_pkg::OP_SD, id_pkg::OP_NONE, id_pkg::OP_NONE,
                                   id_pkg::OP_NONE, id_pkg::OP_NONE};
    id_pkg::op_e branch_ops [8] = '{id_pkg::OP_BEQ, id_pkg::OP_BNE, id_pkg::OP_NONE,
                                    id_pkg::OP_NONE, id_pkg::OP_BLT, id_pkg::OP_BGE,
                                    id_pkg::OP_BLTU, id_pkg::OP_BGEU};
    logic [6:0]  opc_tab [10] = '{`ID_OPC_OP, `ID_OPC_OP_IMM, `ID_OPC_LOAD, `ID_OPC_STORE,
                                  `ID_OPC_BRANCH, `ID_OPC_LUI, `ID_OPC_AUIPC, `ID_OPC_JAL,
                                  `ID_OPC_JALR, `ID_OPC_SYSTEM};
    logic [11:0] csr_tab [4] = '{`ID_CSR_MSTATUS, `ID_CSR_MTVEC, `ID_CSR_MEPC, `ID_CSR_MCAUSE};

    id_stage_top id_stage_top_i (
        .clk      (clk),
        .rst      (rst),
        .valid_id (valid_id),
        .pc_id    (pc_id),
        .inst_id  (inst_id),
        .ready_ex (ready_ex),
        .gpr      (gpr),
        .gpr_busy (gpr_busy),
        .mstatus  (mstatus),
        .mtvec    (mtvec),
        .mepc     (mepc),
        .mcause   (mcause),
        .ready_id (ready_id),
        .valid_ex (valid_ex),
        .pc_ex    (pc_ex),
        .inst_ex  (inst_ex),
        .op       (op),
        .rd       (rd),
        .wen      (wen),
        .src_a    (src_a),
        .src_b    (src_b),
        .imm      (imm)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;                  // 4 ns period
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // template word: random fields on a kept major opcode, or a raw random word
    function automatic logic [31:0] gen_inst(input bit raw_words);
        logic [31:0] w;
        int          k;
        w = next_rand();
        if (raw_words || next_rand() % 32'd8 == 32'd0) begin
            return w;
        end
        k = int'(next_rand() % 32'd10);
        w[6:0] = opc_tab[k];
        k = int'(next_rand() % 32'd4);
        if (k == 0) w[31:25] = 7'h00;
        if (k == 1) w[31:25] = 7'h20;           // sub, srai
        if (k == 2) w[31:25] = 7'h01;           // mul group, or shamt bit 5
        k = int'(next_rand() % 32'd5);
        if (w[6:0] == `ID_OPC_SYSTEM && k < 4) w[31:20] = csr_tab[k];
        return w;
    endfunction

    function automatic void ref_decode(input logic [31:0] w, output id_pkg::op_e o,
                                       output logic e_wen, output logic use1,
                                       output logic use2, output id_pkg::xword_t e_imm);
        logic [2:0] f3;
        logic [6:0] f7;
        f3 = w[14:12];
        f7 = w[31:25];
        o  = id_pkg::OP_NONE;
        case (w[6:0])
            `ID_OPC_OP: begin
                if (f7 == 7'h20 && f3 == 3'd0) o = id_pkg::OP_SUB;
                else if (f7 == 7'h00) o = reg_ops[f3];
            end
            `ID_OPC_OP_IMM: begin
                o = imm_ops[f3];
                if (f3 == 3'd1 && w[31:26] == 6'h00) o = id_pkg::OP_SLLI;
                if (f3 == 3'd5 && w[31:26] == 6'h00) o = id_pkg::OP_SRLI;
                if (f3 == 3'd5 && w[31:26] == 6'h10) o = id_pkg::OP_SRAI;
            end
            `ID_OPC_LOAD:   o = load_ops[f3];
            `ID_OPC_STORE:  o = store_ops[f3];
            `ID_OPC_BRANCH: o = branch_ops[f3];
            `ID_OPC_LUI:    o = id_pkg::OP_LUI;
            `ID_OPC_AUIPC:  o = id_pkg::OP_AUIPC;
            `ID_OPC_JAL:    o = id_pkg::OP_JAL;
            `ID_OPC_JALR: begin
                if (f3 == 3'd0) o = id_pkg::OP_JALR;
            end
            `ID_OPC_SYSTEM: begin
                if (f3 == 3'd1) o = id_pkg::OP_CSRRW;
                if (f3 == 3'd2) o = id_pkg::OP_CSRRS;
            end
            default: ;
        endcase
        e_wen = (o != id_pkg::OP_NONE)
                && !(w[6:0] inside {`ID_OPC_STORE, `ID_OPC_BRANCH});
        use1  = (o != id_pkg::OP_NONE)
                && !(w[6:0] inside {`ID_OPC_LUI, `ID_OPC_AUIPC, `ID_OPC_JAL});
        use2  = (o != id_pkg::OP_NONE)
                && (w[6:0] inside {`ID_OPC_OP, `ID_OPC_STORE, `ID_OPC_BRANCH});
        e_imm = {{52{w[31]}}, w[31:20]};        // I form, also for unknown words
        if (o != id_pkg::OP_NONE) begin
            case (w[6:0])
                `ID_OPC_LUI, `ID_OPC_AUIPC: e_imm = {{32{w[31]}}, w[31:12], 12'h000};
                `ID_OPC_JAL:    e_imm = {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
                `ID_OPC_STORE:  e_imm = {{52{w[31]}}, w[31:25], w[11:7]};
                `ID_OPC_BRANCH: e_imm = {{51{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
                default: ;
            endcase
        end
    endfunction

    function automatic id_pkg::xword_t csr_value(input logic [11:0] addr);
        case (addr)
            `ID_CSR_MSTATUS: return mstatus;
            `ID_CSR_MTVEC:   return mtvec;
            `ID_CSR_MEPC:    return mepc;
            `ID_CSR_MCAUSE:  return mcause;
            default:         return '0;     // unmapped csr reads zero
        endcase
    endfunction

    // stall expected for the item now in the stage register
    function automatic logic front_hazard();
        logic [31:0]    w;
        id_pkg::op_e    o;
        logic           e_wen;
        logic           use1;
        logic           use2;
        id_pkg::xword_t e_imm;
        w = q_inst[0];
        ref_decode(w, o, e_wen, use1, use2, e_imm);
        return (use1 && gpr_busy[w[19:15]]) || (use2 && gpr_busy[w[24:20]]);
    endfunction

    task automatic check(input string what, input logic [63:0] exp, input logic [63:0] act);
        n_checks++;
        if (exp !== act) begin
            $display("[FAIL] %s %s: expected %h, actual %h", cur_test, what, exp, act);
            n_errors++;
            test_errors++;
        end
    endtask

    task automatic compare_item();
        logic [31:0]    w;
        id_pkg::xword_t pc;
        id_pkg::op_e    e_op;
        logic           e_wen;
        logic           use1;
        logic           use2;
        id_pkg::xword_t e_imm;
        id_pkg::xword_t e_b;
        w  = q_inst.pop_front();
        pc = q_pc.pop_front();
        ref_decode(w, e_op, e_wen, use1, use2, e_imm);
        e_b = (e_op inside {id_pkg::OP_CSRRW, id_pkg::OP_CSRRS}) ? csr_value(w[31:20])
                                                                 : gpr[w[24:20]];
        check("inst_ex", 64'(w), 64'(inst_ex));
        check("pc_ex", pc, pc_ex);
        check("op", 64'(e_op), 64'(op));
        check("rd", 64'(w[11:7]), 64'(rd));
        check("wen", 64'(e_wen), 64'(wen));
        check("imm", e_imm, imm);
        check("src_a", gpr[w[19:15]], src_a);
        check("src_b", e_b, src_b);
    endtask

    task automatic randomize_regs();
        for (int i = 0; i < `ID_NREG; i++) begin
            gpr[i] = {next_rand(), next_rand()};
        end
        mstatus = {next_rand(), next_rand()};
        mtvec   = {next_rand(), next_rand()};
        mepc    = {next_rand(), next_rand()};
        mcause  = {next_rand(), next_rand()};
    endtask

    task automatic run_test(input string name, input int n_items, input bit busy_on,
                            input bit bp_on, input bit raw_words);
        int          sent;
        int          done;
        int          cyc;
        logic [31:0] r;
        logic        haz;
        logic        full;
        if (timed_out) begin
            return;
        end
        sent = 0;
        done = 0;
        cyc  = 0;
        cur_test    = name;
        test_errors = 0;
        while (done < n_items && !timed_out) begin
            @(posedge clk);
            #0.5;
            if (cyc == 0) randomize_regs();     // stage is empty here
            r        = next_rand();
            valid_id = (sent < n_items) && (r[1:0] != 2'b00);
            inst_id  = gen_inst(raw_words);
            pc_id    = {next_rand(), next_rand()};
            ready_ex = bp_on ? r[2] : 1'b1;
            gpr_busy = busy_on ? (next_rand() & next_rand() & next_rand()) : '0;
            @(negedge clk);                     // outputs settled
            full = q_inst.size() > 0;
            haz  = full && front_hazard();
            check("valid_ex", 64'(full && !haz), 64'(valid_ex));
            check("ready_id", 64'(!(full && (haz || !ready_ex))), 64'(ready_id));
            if (valid_ex && ready_ex) begin
                if (!full) begin
                    $display("test %s: valid_ex rose with no item in flight", name);
                    n_errors++;
                    test_errors++;
                end else begin
                    compare_item();
                    done++;
                end
            end
            if (valid_id && ready_id) begin
                q_inst.push_back(inst_id);
                q_pc.push_back(pc_id);
                sent++;
            end
            cyc++;
            if (cyc > 40 * n_items) begin
                $display("timeout in test %s: %0d of %0d items came out", name, done, n_items);
                n_errors++;
                test_errors++;
                timed_out = 1'b1;
            end
        end
        $display("test %s: %0d items, %0d errors", name, n_items, test_errors);
    endtask

    initial begin
        rst      = 1'b1;
        valid_id = 1'b0;
        pc_id    = '0;
        inst_id  = '0;
        ready_ex = 1'b0;
        gpr_busy = '0;
        mstatus  = '0;
        mtvec    = '0;
        mepc     = '0;
        mcause   = '0;
        for (int i = 0; i < `ID_NREG; i++) begin
            gpr[i] = '0;
        end
        repeat (3) @(posedge clk);
        #0.5;
        rst = 1'b0;
        @(negedge clk);
        cur_test    = "reset";
        test_errors = 0;
        check("valid_ex", 64'(0), 64'(valid_ex));
        check("ready_id", 64'(1), 64'(ready_id));
        check("op", 64'(id_pkg::OP_NONE), 64'(op));    // empty stage reads as zero word
        check("wen", 64'(0), 64'(wen));
        $display("test reset: %0d errors", test_errors);
        run_test("decode", 300, 1'b0, 1'b0, 1'b0);
        run_test("hazard", 300, 1'b1, 1'b0, 1'b0);
        run_test("backpressure", 300, 1'b0, 1'b1, 1'b0);
        run_test("unknown", 300, 1'b1, 1'b1, 1'b1);
        n_errors += id_stage_top_i.id_stage_properties_i.fail_count;
        $display("checks %0d, errors %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: dv/id_stage_properties.sv
// handshake assertions for the decode stage; reset check needs rst held for at least one edge
`timescale 1ns/100ps
`include "id_params.svh"

module id_stage_properties (
    input logic                  clk,
    input logic                  rst,
    input logic                  valid_ex,
    input logic                  ready_ex,
    input logic                  ready_id,
    input id_pkg::xword_t        pc_ex,
    input logic [`ID_ILEN-1:0]   inst_ex,
    input id_pkg::op_e           op
);

    int fail_count = 0;                         // read by the testbench at the end

    a_idle_after_reset: assert property (@(posedge clk) rst |=> !valid_ex)
        else begin
            fail_count++;
            $error("valid_ex high in the cycle after reset");
        end

    // stalled output item must not move
    a_hold_stable: assert property (@(posedge clk) disable iff (rst)
        valid_ex && !ready_ex |=> $stable(pc_ex) && $stable(inst_ex) && $stable(op))
        else begin
            fail_count++;
            $error("output item changed while stalled by ready_ex");
        end

    a_no_accept_stalled: assert property (@(posedge clk) disable iff (rst)
        !(ready_id && valid_ex && !ready_ex))
        else begin
            fail_count++;
            $error("ready_id high while the output item is stalled");
        end

endmodule

bind id_stage_top id_stage_properties id_stage_properties_i (
    .clk      (clk),
    .rst      (rst),
    .valid_ex (valid_ex),
    .ready_ex (ready_ex),
    .ready_id (ready_id),
    .pc_ex    (pc_ex),
    .inst_ex  (inst_ex),
    .op       (op)
);

// File: hdl/id_stage_top.sv
// decode stage top; outputs are valid one cycle after an upstream transfer unless a source is busy
`timescale 1ns/100ps
`include "id_params.svh"

module id_stage_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   valid_id,
    input  id_pkg::xword_t         pc_id,
    input  logic [`ID_ILEN-1:0]    inst_id,
    input  logic                   ready_ex,
    input  id_pkg::xword_t         gpr [`ID_NREG],
    input  logic [`ID_NREG-1:0]    gpr_busy,
    input  id_pkg::xword_t         mstatus,
    input  id_pkg::xword_t         mtvec,
    input  id_pkg::xword_t         mepc,
    input  id_pkg::xword_t         mcause,
    output logic                   ready_id,
    output logic                   valid_ex,
    output id_pkg::xword_t         pc_ex,
    output logic [`ID_ILEN-1:0]    inst_ex,
    output id_pkg::op_e            op,
    output logic [`ID_REG_W-1:0]   rd,
    output logic                   wen,
    output id_pkg::xword_t         src_a,
    output id_pkg::xword_t         src_b,
    output id_pkg::xword_t         imm
);

    id_pkg::xword_t        pc_q;
    id_pkg::inst_u         inst_q;           // zero when stage empty
    logic                  valid_q;          // raw occupancy, before hazard gating
    logic                  hazard;
    logic [`ID_REG_W-1:0]  rs1;
    logic [`ID_REG_W-1:0]  rs2;
    logic                  use_rs1;
    logic                  use_rs2;

    id_pipe_reg id_pipe_reg_i (
        .clk      (clk),
        .rst      (rst),
        .valid_id (valid_id),
        .pc_id    (pc_id),
        .inst_id  (inst_id),
        .ready_ex (ready_ex),
        .hazard   (hazard),
        .ready_id (ready_id),
        .valid_ex (valid_ex),
        .pc_q     (pc_q),
        .inst_q   (inst_q),
        .valid_q  (valid_q)
    );

    id_decoder id_decoder_i (
        .inst_q  (inst_q),
        .op      (op),
        .rd      (rd),
        .rs1     (rs1),
        .rs2     (rs2),
        .use_rs1 (use_rs1),
        .use_rs2 (use_rs2),
        .wen     (wen)
    );

    id_imm_gen id_imm_gen_i (
        .inst_q (inst_q),
        .op     (op),
        .imm    (imm)
    );

    id_operand_sel id_operand_sel_i (
        .gpr      (gpr),
        .gpr_busy (gpr_busy),
        .rs1      (rs1),
        .rs2      (rs2),
        .use_rs1  (use_rs1 & valid_q),      // empty stage never stalls
        .use_rs2  (use_rs2 & valid_q),
        .op       (op),
        .csr_addr (inst_q.i.imm),           // csr address sits in the I-imm field
        .mstatus  (mstatus),
        .mtvec    (mtvec),
        .mepc     (mepc),
        .mcause   (mcause),
        .src_a    (src_a),
        .src_b    (src_b),
        .hazard   (hazard)
    );

    assign pc_ex   = pc_q;
    assign inst_ex = inst_q;

endmodule

// File: hdl/id_operand_sel.sv
// operand read and raw-hazard check; x0 is not special, its busy bit is trusted as given
`timescale 1ns/100ps
`include "id_params.svh"

module id_operand_sel (
    input  id_pkg::xword_t         gpr [`ID_NREG],
    input  logic [`ID_NREG-1:0]    gpr_busy,
    input  logic [`ID_REG_W-1:0]   rs1,
    input  logic [`ID_REG_W-1:0]   rs2,
    input  logic                   use_rs1,
    input  logic                   use_rs2,
    input  id_pkg::op_e            op,
    input  logic [11:0]            csr_addr,
    input  id_pkg::xword_t         mstatus,
    input  id_pkg::xword_t         mtvec,
    input  id_pkg::xword_t         mepc,
    input  id_pkg::xword_t         mcause,
    output id_pkg::xword_t         src_a,
    output id_pkg::xword_t         src_b,
    output logic                   hazard
);

    id_pkg::xword_t csr_val;                // selected csr, 0 if unmapped
    logic           csr_op;

    always_comb begin
        case (csr_addr)
            `ID_CSR_MSTATUS: csr_val = mstatus;
            `ID_CSR_MTVEC:   csr_val = mtvec;
            `ID_CSR_MEPC:    csr_val = mepc;
            `ID_CSR_MCAUSE:  csr_val = mcause;
            default:         csr_val = '0;
        endcase
    end

    assign csr_op = (op == id_pkg::OP_CSRRW) || (op == id_pkg::OP_CSRRS);

    assign src_a = gpr[rs1];                        // also csr write data
    assign src_b = csr_op ? csr_val : gpr[rs2];     // old csr value for csr ops

    // stall while a used source still has a write pending
    assign hazard = (use_rs1 & gpr_busy[rs1]) | (use_rs2 & gpr_busy[rs2]);

endmodule

// File: hdl/id_imm_gen.sv
// immediate builder; every form sign-extends from inst[31], shamt is left inside the I form
`timescale 1ns/100ps
`include "id_params.svh"

module id_imm_gen (
    input  id_pkg::inst_u   inst_q,
    input  id_pkg::op_e     op,
    output id_pkg::xword_t  imm
);

    id_pkg::xword_t imm_i;
    id_pkg::xword_t imm_s;
    id_pkg::xword_t imm_b;
    id_pkg::xword_t imm_u;
    id_pkg::xword_t imm_j;

    assign imm_i = {{(`ID_XLEN-12){inst_q.i.imm[11]}}, inst_q.i.imm};
    assign imm_s = {{(`ID_XLEN-12){inst_q.s.imm_11_5[6]}}, inst_q.s.imm_11_5,
                    inst_q.s.imm_4_0};
    assign imm_b = {{(`ID_XLEN-13){inst_q.b.imm_12}}, inst_q.b.imm_12, inst_q.b.imm_11,
                    inst_q.b.imm_10_5, inst_q.b.imm_4_1, 1'b0};         // halfword aligned
    assign imm_u = {{(`ID_XLEN-32){inst_q.u.imm_31_12[19]}}, inst_q.u.imm_31_12, 12'b0};
    assign imm_j = {{(`ID_XLEN-21){inst_q.j.imm_20}}, inst_q.j.imm_20, inst_q.j.imm_19_12,
                    inst_q.j.imm_11, inst_q.j.imm_10_1, 1'b0};

    always_comb begin
        case (op)
            id_pkg::OP_LUI, id_pkg::OP_AUIPC: imm = imm_u;
            id_pkg::OP_JAL:                   imm = imm_j;
            id_pkg::OP_SB, id_pkg::OP_SH,
            id_pkg::OP_SW, id_pkg::OP_SD:     imm = imm_s;
            id_pkg::OP_BEQ, id_pkg::OP_BNE, id_pkg::OP_BLT,
            id_pkg::OP_BGE, id_pkg::OP_BLTU,
            id_pkg::OP_BGEU:                  imm = imm_b;
            default:                          imm = imm_i;   // incl. OP_NONE
        endcase
    end

endmodule

// File: hdl/id_decoder.sv
// RV64I subset decoder; illegal or dropped encodings (M ext, word ops, ecall/mret) give OP_NONE
`timescale 1ns/100ps
`include "id_params.svh"

module id_decoder (
    input  id_pkg::inst_u          inst_q,
    output id_pkg::op_e            op,
    output logic [`ID_REG_W-1:0]   rd,
    output logic [`ID_REG_W-1:0]   rs1,
    output logic [`ID_REG_W-1:0]   rs2,
    output logic                   use_rs1,
    output logic                   use_rs2,
    output logic                   wen
);

    logic [5:0] funct6;                     // rv64 shifts carry 6-bit shamt

    assign funct6 = inst_q.r.funct7[6:1];
    assign rd     = inst_q.r.rd;
    assign rs1    = inst_q.r.rs1;
    assign rs2    = inst_q.r.rs2;

    always_comb begin
        op = id_pkg::OP_NONE;               // default for anything unmatched
        case (inst_q.r.opcode)
            `ID_OPC_OP: begin
                case ({inst_q.r.funct7, inst_q.r.funct3})
                    10'b0000000_000: op = id_pkg::OP_ADD;
                    10'b0100000_000: op = id_pkg::OP_SUB;
                    10'b0000000_001: op = id_pkg::OP_SLL;
                    10'b0000000_010: op = id_pkg::OP_SLT;
                    10'b0000000_011: op = id_pkg::OP_SLTU;
                    10'b0000000_100: op = id_pkg::OP_XOR;
                    10'b0000000_101: op = id_pkg::OP_SRL;
                    10'b0000000_110: op = id_pkg::OP_OR;
                    10'b0000000_111: op = id_pkg::OP_AND;
                    default:         op = id_pkg::OP_NONE;   // mul/div land here
                endcase
            end
            `ID_OPC_OP_IMM: begin
                case (inst_q.i.funct3)
                    3'b000: op = id_pkg::OP_ADDI;
                    3'b010: op = id_pkg::OP_SLTI;
                    3'b011: op = id_pkg::OP_SLTIU;
                    3'b100: op = id_pkg::OP_XORI;
                    3'b110: op = id_pkg::OP_ORI;
                    3'b111: op = id_pkg::OP_ANDI;
                    3'b001: if (funct6 == 6'b000000) op = id_pkg::OP_SLLI;
                    3'b101: begin
                        if (funct6 == 6'b000000)      op = id_pkg::OP_SRLI;
                        else if (funct6 == 6'b010000) op = id_pkg::OP_SRAI;
                    end
                    default: op = id_pkg::OP_NONE;
                endcase
            end
            `ID_OPC_LOAD: begin
                case (inst_q.i.funct3)
                    3'b000:  op = id_pkg::OP_LB;
                    3'b001:  op = id_pkg::OP_LH;
                    3'b010:  op = id_pkg::OP_LW;
                    3'b011:  op = id_pkg::OP_LD;
                    3'b100:  op = id_pkg::OP_LBU;
                    3'b101:  op = id_pkg::OP_LHU;
                    3'b110:  op = id_pkg::OP_LWU;
                    default: op = id_pkg::OP_NONE;
                endcase
            end
            `ID_OPC_STORE: begin
                case (inst_q.s.funct3)
                    3'b000:  op = id_pkg::OP_SB;
                    3'b001:  op = id_pkg::OP_SH;
                    3'b010:  op = id_pkg::OP_SW;
                    3'b011:  op = id_pkg::OP_SD;
                    default: op = id_pkg::OP_NONE;
                endcase
            end
            `ID_OPC_BRANCH: begin
                case (inst_q.b.funct3)
                    3'b000:  op = id_pkg::OP_BEQ;
                    3'b001:  op = id_pkg::OP_BNE;
                    3'b100:  op = id_pkg::OP_BLT;
                    3'b101:  op = id_pkg::OP_BGE;
                    3'b110:  op = id_pkg::OP_BLTU;
                    3'b111:  op = id_pkg::OP_BGEU;
                    default: op = id_pkg::OP_NONE;
                endcase
            end
            `ID_OPC_LUI:   op = id_pkg::OP_LUI;
            `ID_OPC_AUIPC: op = id_pkg::OP_AUIPC;
            `ID_OPC_JAL:   op = id_pkg::OP_JAL;
            `ID_OPC_JALR:  if (inst_q.i.funct3 == 3'b000) op = id_pkg::OP_JALR;
            `ID_OPC_SYSTEM: begin
                if (inst_q.i.funct3 == 3'b001)      op = id_pkg::OP_CSRRW;
                else if (inst_q.i.funct3 == 3'b010) op = id_pkg::OP_CSRRS;
            end
            default: op = id_pkg::OP_NONE;
        endcase
    end

    // register usage follows the operation class
    always_comb begin
        wen     = 1'b0;
        use_rs1 = 1'b1;                     // most ops read rs1
        use_rs2 = 1'b0;
        case (op)
            id_pkg::OP_NONE: use_rs1 = 1'b0;
            id_pkg::OP_ADD, id_pkg::OP_SUB, id_pkg::OP_SLL, id_pkg::OP_SLT,
            id_pkg::OP_SLTU, id_pkg::OP_XOR, id_pkg::OP_SRL, id_pkg::OP_OR,
            id_pkg::OP_AND: begin
                wen     = 1'b1;
                use_rs2 = 1'b1;
            end
            id_pkg::OP_SB, id_pkg::OP_SH, id_pkg::OP_SW, id_pkg::OP_SD,
            id_pkg::OP_BEQ, id_pkg::OP_BNE, id_pkg::OP_BLT, id_pkg::OP_BGE,
            id_pkg::OP_BLTU, id_pkg::OP_BGEU: use_rs2 = 1'b1;   // no rd
            id_pkg::OP_LUI, id_pkg::OP_AUIPC, id_pkg::OP_JAL: begin
                wen     = 1'b1;
                use_rs1 = 1'b0;             // u/j forms have no rs1
            end
            default: wen = 1'b1;            // imm alu, loads, jalr, csr
        endcase
    end

endmodule

// File: hdl/id_pipe_reg.sv
// one-entry decode register; holds on hazard or downstream stall, so one item in flight at most
`timescale 1ns/100ps
`include "id_params.svh"

module id_pipe_reg (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   valid_id,
    input  id_pkg::xword_t         pc_id,
    input  logic [`ID_ILEN-1:0]    inst_id,
    input  logic                   ready_ex,
    input  logic                   hazard,
    output logic                   ready_id,
    output logic                   valid_ex,
    output id_pkg::xword_t         pc_q,
    output id_pkg::inst_u          inst_q,
    output logic                   valid_q
);

    logic                valid_r;           // stage occupied
    id_pkg::xword_t      pc_r;
    logic [`ID_ILEN-1:0] inst_r;
    logic                hold;              // keep current item

    assign hold = valid_r & (hazard | ~ready_ex);

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_r <= 1'b0;
        end else if (!hold) begin
            valid_r <= valid_id;            // bubble when fetch idle
        end
    end

    always_ff @(posedge clk) begin
        if (!hold) begin
            pc_r   <= pc_id;
            inst_r <= inst_id;
        end
    end

    assign ready_id = ~hold;
    assign valid_ex = valid_r & ~hazard;    // no issue while a source is busy
    assign valid_q  = valid_r;
    assign pc_q     = pc_r;
    // empty stage presents all-zero word, decodes as OP_NONE
    assign inst_q   = valid_r ? inst_r : '0;

endmodule

// File: hdl/id_pkg.sv
// types shared by the decode stage; op_e covers the kept RV64I subset only, no word ops
`include "id_params.svh"

package id_pkg;

    typedef logic [`ID_XLEN-1:0] xword_t;      // one gpr / csr value

    typedef struct packed {
        logic [6:0]           funct7;
        logic [`ID_REG_W-1:0] rs2;
        logic [`ID_REG_W-1:0] rs1;
        logic [2:0]           funct3;
        logic [`ID_REG_W-1:0] rd;
        logic [6:0]           opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]          imm;             // also the csr address
        logic [`ID_REG_W-1:0] rs1;
        logic [2:0]           funct3;
        logic [`ID_REG_W-1:0] rd;
        logic [6:0]           opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0]           imm_11_5;
        logic [`ID_REG_W-1:0] rs2;
        logic [`ID_REG_W-1:0] rs1;
        logic [2:0]           funct3;
        logic [4:0]           imm_4_0;
        logic [6:0]           opcode;
    } s_fmt_t;

    typedef struct packed {
        logic                 imm_12;
        logic [5:0]           imm_10_5;
        logic [`ID_REG_W-1:0] rs2;
        logic [`ID_REG_W-1:0] rs1;
        logic [2:0]           funct3;
        logic [3:0]           imm_4_1;
        logic                 imm_11;
        logic [6:0]           opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0]          imm_31_12;
        logic [`ID_REG_W-1:0] rd;
        logic [6:0]           opcode;
    } u_fmt_t;

    typedef struct packed {
        logic                 imm_20;
        logic [9:0]           imm_10_1;
        logic                 imm_11;
        logic [7:0]           imm_19_12;
        logic [`ID_REG_W-1:0] rd;
        logic [6:0]           opcode;
    } j_fmt_t;

    // same 32-bit word, one view per format
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } inst_u;

    typedef enum logic [5:0] {
        OP_NONE = 6'd0,                                  // unknown word or bubble
        OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU,
        OP_XOR, OP_SRL, OP_OR, OP_AND,
        OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI, OP_ANDI,
        OP_SLLI, OP_SRLI, OP_SRAI,
        OP_LB, OP_LH, OP_LW, OP_LD, OP_LBU, OP_LHU, OP_LWU,
        OP_SB, OP_SH, OP_SW, OP_SD,
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
        OP_LUI, OP_AUIPC, OP_JAL, OP_JALR,
        OP_CSRRW, OP_CSRRS
    } op_e;

endpackage

// File: hdl/id_params.svh
// widths and encodings for the RV64I decode stage; only mstatus/mtvec/mepc/mcause are mapped
`ifndef ID_PARAMS_SVH
`define ID_PARAMS_SVH

`define ID_XLEN   64                    // data word
`define ID_ILEN   32                    // instruction word, no compressed forms
`define ID_NREG   32                    // integer register file
`define ID_REG_W  5                     // register index

// major opcodes, inst[6:0]
`define ID_OPC_OP      7'b0110011       // reg-reg alu
`define ID_OPC_OP_IMM  7'b0010011       // reg-imm alu and shifts
`define ID_OPC_LOAD    7'b0000011
`define ID_OPC_STORE   7'b0100011
`define ID_OPC_BRANCH  7'b1100011
`define ID_OPC_LUI     7'b0110111
`define ID_OPC_AUIPC   7'b0010111
`define ID_OPC_JAL     7'b1101111
`define ID_OPC_JALR    7'b1100111
`define ID_OPC_SYSTEM  7'b1110011       // csr access only

// machine csr addresses
`define ID_CSR_MSTATUS 12'h300
`define ID_CSR_MTVEC   12'h305
`define ID_CSR_MEPC    12'h341
`define ID_CSR_MCAUSE  12'h342

`endif
